// File: hdl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// field widths
`define CSR_NUM_W       14
`define CSR_DATA_W      32
`define ECODE_W         6
`define ESUBCODE_W      9
`define PLV_W           2
`define INT_VEC_W       13

// register addresses
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUBCODE_ADEF   9'h000

`define ECFG_LIE_MASK   13'h1bff    // bit 10 reserved
`define TIMER_IDLE      32'hffff_ffff

`endif

// File: hdl/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;
    typedef logic [`ECODE_W-1:0]    ecode_t;
    typedef logic [`ESUBCODE_W-1:0] esubcode_t;
    typedef logic [`PLV_W-1:0]      plv_t;

    // 1:0 sw, 9:2 hw, 10 reserved, 11 timer, 12 ipi
    typedef logic [`INT_VEC_W-1:0]  int_vec_t;

    // single-cycle write strobe from writeback
    typedef struct packed {
        logic      we;
        csr_num_t  num;
        csr_data_t mask;
        csr_data_t value;
    } csr_write_t;

    typedef struct packed {
        logic      ex_valid;
        logic      ertn_valid;
        ecode_t    ecode;
        esubcode_t esubcode;
        csr_data_t pc;
        csr_data_t vaddr;       // memory access address
    } trap_event_t;

    // masked bits from value, the rest kept
    function automatic csr_data_t csr_merge(
        input csr_data_t mask,
        input csr_data_t value,
        input csr_data_t old
    );
        return (mask & value) | (~mask & old);
    endfunction

endpackage

// File: hdl/csr_trap_regs.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_trap_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  wr,
    input  csr_pkg::csr_num_t    rd_num,
    input  csr_pkg::trap_event_t trap,
    input  logic [7:0]           hw_int,
    input  logic                 timer_int,
    output csr_pkg::csr_data_t   rd_word,
    output csr_pkg::csr_data_t   ex_entry,
    output csr_pkg::csr_data_t   ertn_entry,
    output logic                 has_int
);
    import csr_pkg::*;

    plv_t        crmd_plv;
    logic        crmd_ie;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    int_vec_t    ecfg_lie;
    logic [1:0]  estat_sw;          // software writable is bits
    logic [7:0]  estat_hw;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_data_t   era;
    csr_data_t   badv;
    logic [25:0] eentry_va;

    int_vec_t    estat_is;
    csr_data_t   crmd_word;
    csr_data_t   prmd_word;
    csr_data_t   ecfg_word;
    csr_data_t   estat_word;
    csr_data_t   eentry_word;
    logic        addr_err;

    assign estat_is    = {1'b0, timer_int, 1'b0, estat_hw, estat_sw};    // ipi not wired
    assign crmd_word   = {29'b0, crmd_ie, crmd_plv};
    assign prmd_word   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_word   = {19'b0, ecfg_lie};
    assign estat_word  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry_word = {eentry_va, 6'b0};

    assign addr_err = (trap.ecode == `ECODE_ALE) || (trap.ecode == `ECODE_ADE);

    // exception > return > software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ex_valid) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn_valid) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == `CSR_CRMD) begin
            {crmd_ie, crmd_plv} <= 3'(csr_merge(wr.mask, wr.value, crmd_word));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (trap.ex_valid) begin
            prmd_pplv <= crmd_plv;      // save mode at entry
            prmd_pie  <= crmd_ie;
        end else if (wr.we && wr.num == `CSR_PRMD) begin
            {prmd_pie, prmd_pplv} <= 3'(csr_merge(wr.mask, wr.value, prmd_word));
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            ecfg_lie <= '0;
        else if (wr.we && wr.num == `CSR_ECFG)
            ecfg_lie <= int_vec_t'(csr_merge(wr.mask, wr.value, ecfg_word)) & `ECFG_LIE_MASK;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_sw       <= '0;
            estat_hw       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            estat_hw <= hw_int;         // sampled lines
            if (wr.we && wr.num == `CSR_ESTAT)
                estat_sw <= 2'(csr_merge(wr.mask, wr.value, estat_word));
            if (trap.ex_valid) begin
                estat_ecode    <= trap.ecode;
                estat_esubcode <= trap.esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            era <= '0;
        else if (trap.ex_valid)
            era <= trap.pc;
        else if (wr.we && wr.num == `CSR_ERA)
            era <= csr_merge(wr.mask, wr.value, era);
    end

    // fetch fault reports the pc itself
    always_ff @(posedge clk) begin
        if (reset)
            badv <= '0;
        else if (trap.ex_valid && addr_err)
            badv <= (trap.ecode == `ECODE_ADE && trap.esubcode == `ESUBCODE_ADEF) ?
                    trap.pc : trap.vaddr;
        else if (wr.we && wr.num == `CSR_BADV)
            badv <= csr_merge(wr.mask, wr.value, badv);
    end

    always_ff @(posedge clk) begin
        if (reset)
            eentry_va <= '0;
        else if (wr.we && wr.num == `CSR_EENTRY)
            eentry_va <= 26'(csr_merge(wr.mask, wr.value, eentry_word) >> 6);
    end

    assign has_int    = (|(estat_is[11:0] & ecfg_lie[11:0])) & crmd_ie;
    assign ex_entry   = eentry_word;
    assign ertn_entry = era;

    assign rd_word = {32{rd_num == `CSR_CRMD  }} & crmd_word
                   | {32{rd_num == `CSR_PRMD  }} & prmd_word
                   | {32{rd_num == `CSR_ECFG  }} & ecfg_word
                   | {32{rd_num == `CSR_ESTAT }} & estat_word
                   | {32{rd_num == `CSR_ERA   }} & era
                   | {32{rd_num == `CSR_BADV  }} & badv
                   | {32{rd_num == `CSR_EENTRY}} & eentry_word;

endmodule

// File: hdl/csr_timer.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_timer (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::csr_num_t   rd_num,
    output csr_pkg::csr_data_t  rd_word,
    output logic                timer_int
);
    import csr_pkg::*;

    csr_data_t   tid;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_data_t   timer_cnt;
    logic        timer_flag;

    logic        wr_tcfg;
    csr_data_t   tcfg_word;
    csr_data_t   tcfg_next;
    logic        ticlr_clr;

    assign wr_tcfg   = wr.we && (wr.num == `CSR_TCFG);
    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = csr_merge(wr.mask, wr.value, tcfg_word);
    assign ticlr_clr = wr.we && (wr.num == `CSR_TICLR) && wr.mask[0] && wr.value[0];

    always_ff @(posedge clk) begin
        if (reset)
            tid <= '0;
        else if (wr.we && wr.num == `CSR_TID)
            tid <= csr_merge(wr.mask, wr.value, tid);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            {tcfg_initval, tcfg_periodic, tcfg_en} <= tcfg_next;
        end
    end

    // all-ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b0};
            else
                timer_cnt <= timer_cnt - 1'b1;  // one-shot wraps to idle
        end
    end

    // set beats clear
    always_ff @(posedge clk) begin
        if (reset)
            timer_flag <= 1'b0;
        else if (tcfg_en && timer_cnt == '0)
            timer_flag <= 1'b1;
        else if (ticlr_clr)
            timer_flag <= 1'b0;
    end

    assign timer_int = timer_flag;

    // clear register reads zero
    assign rd_word = {32{rd_num == `CSR_TID }} & tid
                   | {32{rd_num == `CSR_TCFG}} & tcfg_word
                   | {32{rd_num == `CSR_TVAL}} & timer_cnt;

endmodule

// File: hdl/csr_save_regs.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_save_regs (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::csr_num_t   rd_num,
    output csr_pkg::csr_data_t  rd_word
);
    import csr_pkg::*;

    localparam csr_num_t SAVE_NUM [4] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};

    csr_data_t save_q [4];

    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (reset)
                save_q[i] <= '0;
            else if (wr.we && wr.num == SAVE_NUM[i])
                save_q[i] <= csr_merge(wr.mask, wr.value, save_q[i]);
        end
    end

    always_comb begin
        rd_word = '0;
        for (int i = 0; i < 4; i++) begin
            if (rd_num == SAVE_NUM[i])
                rd_word = save_q[i];
        end
    end

endmodule

// File: hdl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  wr,
    input  csr_pkg::csr_num_t    rd_num,
    input  csr_pkg::trap_event_t trap,
    input  logic [7:0]           hw_int,
    output csr_pkg::csr_data_t   rd_data,
    output csr_pkg::csr_data_t   ex_entry,
    output csr_pkg::csr_data_t   ertn_entry,
    output logic                 has_int
);
    import csr_pkg::*;

    csr_data_t trap_rd;
    csr_data_t timer_rd;
    csr_data_t save_rd;
    logic      timer_int;

    csr_trap_regs u_trap (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .rd_num     (rd_num),
        .trap       (trap),
        .hw_int     (hw_int),
        .timer_int  (timer_int),
        .rd_word    (trap_rd),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd_num    (rd_num),
        .rd_word   (timer_rd),
        .timer_int (timer_int)
    );

    csr_save_regs u_save (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .rd_num  (rd_num),
        .rd_word (save_rd)
    );

    // groups return zero outside their own addresses
    assign rd_data = trap_rd | timer_rd | save_rd;

endmodule

// File: tests/csr_tb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int ITERS      = 6;      // random writes per register
    localparam int MAX_INIT   = 10;     // largest timer initial value
    localparam int WATCHDOG_CYCLES = 10 + 16 + 8 * ITERS + 16 + (4 * MAX_INIT + 8) + 40 + 200;

    localparam csr_num_t ZERO_REGS [14] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT,
        `CSR_ERA, `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_TID, `CSR_TCFG, `CSR_TICLR};
    localparam csr_num_t WR_REGS [7] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_ECFG, `CSR_EENTRY, `CSR_TID};
    // bits that hold state, the rest read zero
    localparam csr_data_t WR_KEEP [7] = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
        32'hffff_ffff, 32'h0000_1bff, 32'hffff_ffc0, 32'hffff_ffff};

    logic        clk = 1'b0;
    logic        reset;
    csr_write_t  wr;
    csr_num_t    rd_num;
    trap_event_t trap;
    logic [7:0]  hw_int;
    csr_data_t   rd_data;
    csr_data_t   ex_entry;
    csr_data_t   ertn_entry;
    logic        has_int;

    logic [15:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    csr_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .rd_num     (rd_num),
        .trap       (trap),
        .hw_int     (hw_int),
        .rd_data    (rd_data),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output csr_data_t r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    // one cycle: drive on the falling edge, return just after the rising edge
    task automatic step(input csr_write_t w, input trap_event_t t, input csr_num_t num);
        @(negedge clk);
        wr = w;
        trap = t;
        rd_num = num;
        @(posedge clk);
        #1;
    endtask

    task automatic write_read(input csr_num_t num, input csr_data_t mask,
                              input csr_data_t value, input csr_num_t rnum);
        csr_write_t w;
        w.we = 1'b1;
        w.num = num;
        w.mask = mask;
        w.value = value;
        step(w, '0, rnum);
    endtask

    task automatic write_csr(input csr_num_t num, input csr_data_t mask, input csr_data_t value);
        write_read(num, mask, value, num);
    endtask

    task automatic raise_trap(input logic ex, input logic ertn, input ecode_t ecode,
                              input esubcode_t esub, input csr_data_t pc, input csr_data_t va,
                              input csr_num_t rnum);
        trap_event_t t;
        t.ex_valid = ex;
        t.ertn_valid = ertn;
        t.ecode = ecode;
        t.esubcode = esub;
        t.pc = pc;
        t.vaddr = va;
        step('0, t, rnum);
    endtask

    task automatic drive_hw(input logic [7:0] lines);
        @(negedge clk);
        wr = '0;
        trap = '0;
        hw_int = lines;
        rd_num = `CSR_ESTAT;
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input csr_data_t exp, input csr_data_t act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input csr_num_t num, input csr_data_t exp);
        step('0, '0, num);
        check(name, exp, rd_data);
    endtask

    task automatic fail(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic end_test(input string name, input int start_err);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start_err);
    endtask

    initial begin
        csr_data_t m;
        csr_data_t v;
        csr_data_t pc;
        csr_data_t va;
        csr_data_t init;
        csr_data_t prev;
        csr_data_t model [7];
        int        t_err;
        bit        seen;

        lfsr = 16'd6815;
        reset = 1'b1;
        wr = '0;
        rd_num = '0;
        trap = '0;
        hw_int = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        t_err = errors;
        for (int i = 0; i < 14; i++)
            read_check("reset_values", ZERO_REGS[i], '0);
        read_check("reset_values tval", `CSR_TVAL, `TIMER_IDLE);
        check("reset_values has_int", 32'd0, {31'b0, has_int});
        end_test("reset_values", t_err);

        t_err = errors;
        for (int i = 0; i < 7; i++)
            model[i] = '0;
        for (int n = 0; n < ITERS; n++) begin
            for (int i = 0; i < 7; i++) begin
                rand_bits(32, m);
                rand_bits(32, v);
                model[i] = ((m & v) | (~m & model[i])) & WR_KEEP[i];
                write_csr(WR_REGS[i], m, v);
                check("masked_writes", model[i], rd_data);
            end
            check("masked_writes ex_entry", model[5], ex_entry);
        end
        for (int i = 0; i < 7; i++)
            read_check("masked_writes reread", WR_REGS[i], model[i]);
        end_test("masked_writes", t_err);

        t_err = errors;
        write_csr(`CSR_CRMD, 32'h7, 32'h7);     // plv 3, ie 1
        check("trap crmd write", 32'h7, rd_data);
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_trap(1'b1, 1'b0, `ECODE_ALE, 9'h000, pc, va, `CSR_CRMD);
        check("trap entry crmd", 32'h0, rd_data);
        read_check("trap entry prmd", `CSR_PRMD, 32'h7);
        read_check("trap entry era", `CSR_ERA, pc);
        check("trap ertn_entry", pc, ertn_entry);
        step('0, '0, `CSR_ESTAT);
        check("trap estat codes", {17'b0, 9'h000, `ECODE_ALE}, {17'b0, rd_data[30:16]});
        read_check("trap ale badv", `CSR_BADV, va);
        raise_trap(1'b0, 1'b1, '0, '0, '0, '0, `CSR_CRMD);
        check("trap return crmd", 32'h7, rd_data);
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_trap(1'b1, 1'b0, `ECODE_ADE, `ESUBCODE_ADEF, pc, va, `CSR_BADV);
        check("trap adef badv", pc, rd_data);
        step('0, '0, `CSR_ESTAT);
        check("trap adef codes", {17'b0, `ESUBCODE_ADEF, `ECODE_ADE}, {17'b0, rd_data[30:16]});
        raise_trap(1'b0, 1'b1, '0, '0, '0, '0, `CSR_CRMD);
        check("trap second return crmd", 32'h7, rd_data);
        end_test("trap_entry_return", t_err);

        t_err = errors;
        rand_bits(3, init);
        init = init + 3;
        write_read(`CSR_TCFG, '1, {init[29:0], 2'b01}, `CSR_TVAL);
        check("timer load", init << 2, rd_data);
        prev = rd_data;
        seen = 1'b0;
        for (int n = 0; n < 4 * MAX_INIT + 4 && !seen; n++) begin
            step('0, '0, `CSR_TVAL);
            if (rd_data === `TIMER_IDLE) begin
                seen = 1'b1;
            end else begin
                checks++;
                assert (rd_data <= prev) else begin
                    $display("timer counter rose from %h to %h", prev, rd_data);
                    errors++;
                end
                prev = rd_data;
            end
        end
        checks++;
        assert (seen) else fail("timer counter never reached all ones");
        step('0, '0, `CSR_ESTAT);
        check("timer flag set", 32'd1, {31'b0, rd_data[11]});
        write_read(`CSR_TICLR, 32'h1, 32'h1, `CSR_ESTAT);
        check("timer flag clear", 32'd0, {31'b0, rd_data[11]});
        read_check("timer ticlr reads zero", `CSR_TICLR, '0);
        end_test("timer_one_shot", t_err);

        t_err = errors;
        write_read(`CSR_TCFG, '1, 32'h5, `CSR_ESTAT);   // initial value 1, one-shot
        seen = 1'b0;
        for (int n = 0; n < 16 && !seen; n++) begin
            step('0, '0, `CSR_ESTAT);
            seen = rd_data[11];
        end
        checks++;
        assert (seen) else fail("timer interrupt never became pending");
        write_csr(`CSR_ECFG, '1, 32'h0);
        check("has_int no enable", 32'd0, {31'b0, has_int});
        write_csr(`CSR_ECFG, '1, 32'h800);
        check("has_int timer enabled", 32'd1, {31'b0, has_int});
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        check("has_int global off", 32'd0, {31'b0, has_int});
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        check("has_int global on", 32'd1, {31'b0, has_int});
        write_csr(`CSR_ECFG, '1, 32'h0);
        write_read(`CSR_TICLR, 32'h1, 32'h1, `CSR_ESTAT);
        rand_bits(3, m);
        drive_hw(8'b1 << m[2:0]);
        check("hw status bit", {24'b0, 8'b1 << m[2:0]}, {24'b0, rd_data[9:2]});
        check("has_int hw masked", 32'd0, {31'b0, has_int});
        write_csr(`CSR_ECFG, '1, 32'h4 << m[2:0]);
        check("has_int hw enabled", 32'd1, {31'b0, has_int});
        drive_hw(8'h00);
        check("hw status cleared", 32'd0, {24'b0, rd_data[9:2]});
        check("has_int hw dropped", 32'd0, {31'b0, has_int});
        end_test("interrupt_pending", t_err);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_save_regs.sv
hdl/csr_top.sv
tests/csr_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= csr_tb
LINT_TOP   ?= csr_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
